//--- lb_cfg.svh
// Loopback exerciser configuration macros for beat width, segmentation and buffer depth
`ifndef LB_CFG_SVH
`define LB_CFG_SVH

// --------------------------------------------------
// Host channel beat layout
// --------------------------------------------------

// Payload bits per beat
`define LB_DATA_W 64

// Segments per beat, each carrying its own EOP flag
`define LB_NUM_SEG 2

// --------------------------------------------------
// Loopback buffer
// --------------------------------------------------

// Entries in the loopback FIFO
// Power of two, at least 2, so pointers wrap on their own
`define LB_FIFO_DEPTH 4

`endif

//--- lb_pkg.sv
// Loopback exerciser package with the beat field types and segment constants
`include "lb_cfg.svh"

package lb_pkg;

   // --------------------------------------------------
   // Beat field types
   // --------------------------------------------------

   // Beat payload
   typedef logic [`LB_DATA_W-1:0] lb_data_t;

   // Byte enables, one bit per payload byte
   // Bit s * lb_seg_bytes is the base keep bit of segment s
   typedef logic [`LB_DATA_W/8-1:0] lb_keep_t;

   // One flag per segment, used for the EOP vector
   typedef logic [`LB_NUM_SEG-1:0] lb_seg_t;

   // --------------------------------------------------
   // Derived constants
   // --------------------------------------------------

   // Bytes in one segment
   // Also the stride between base keep bits
   localparam int lb_seg_bytes = `LB_DATA_W / 8 / `LB_NUM_SEG;

endpackage

//--- lb_stream_if.sv
// Internal valid/ready beat stream between the loopback stages
interface lb_stream_if;

   import lb_pkg::*;

   // Handshake
   logic     valid;
   logic     ready;

   // Beat fields, held stable by the source while valid waits for ready
   lb_data_t data;
   lb_keep_t keep;
   logic     last;

   // Data-mover mode flag, carried through unchanged
   logic     dm_mode;

   // Producer side of the stream
   modport src (
      output valid,
      output data,
      output keep,
      output last,
      output dm_mode,
      input  ready
   );

   // Consumer side of the stream
   modport snk (
      input  valid,
      input  data,
      input  keep,
      input  last,
      input  dm_mode,
      output ready
   );

endinterface

//--- host_rx_map.sv
// Receive mapper, a two-entry skid stage from host rx beats onto the internal stream
module host_rx_map (
   input  logic              plat_ifc,
   input  logic              arst_n,
   input  logic              rx_tvalid,
   input  lb_pkg::lb_data_t  rx_tdata,
   input  lb_pkg::lb_keep_t  rx_tkeep,
   input  logic              rx_tlast,
   input  logic              rx_dm_mode,
   output logic              rx_tready,
   lb_stream_if.src          out_s
);

   import lb_pkg::*;

   // Packed beat, mode on top, then last, keep and data
   localparam int BEAT_W = $bits(lb_data_t) + $bits(lb_keep_t) + 2;

   logic [BEAT_W-1:0] rx_beat;
   logic [BEAT_W-1:0] main_beat;
   logic [BEAT_W-1:0] skid_beat;
   logic              main_valid;
   logic              skid_valid;
   logic              rx_fire;
   logic              out_fire;
   logic              load_main_rx;
   logic              load_main_skid;
   logic              load_skid;

   // --------------------------------------------------
   // Handshakes
   // --------------------------------------------------

   assign rx_beat  = {rx_dm_mode, rx_tlast, rx_tkeep, rx_tdata};

   // Host sees a flop, never the downstream ready
   // Skid is only ever full while main is full too
   assign rx_tready = ~skid_valid;

   assign rx_fire  = rx_tvalid & rx_tready;
   assign out_fire = main_valid & out_s.ready;

   // Main takes the host beat when empty or emptying without a waiting skid beat
   assign load_main_rx   = rx_fire & (~main_valid | (out_fire & ~skid_valid));
   // Waiting skid beat moves up as main leaves
   assign load_main_skid = out_fire & skid_valid;
   // Host beat parks in the skid entry while main is stalled
   assign load_skid      = rx_fire & main_valid & ~out_fire;

   // --------------------------------------------------
   // Occupancy flags
   // --------------------------------------------------

   always_ff @(posedge plat_ifc or negedge arst_n)
   begin
      if (!arst_n)
      begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end
      else
      begin
         if (load_main_rx || load_main_skid)
            main_valid <= 1'b1;
         else if (out_fire)
            main_valid <= 1'b0;

         if (load_skid)
            skid_valid <= 1'b1;
         else if (load_main_skid)
            skid_valid <= 1'b0;
      end
   end

   // Payload entries
   always_ff @(posedge plat_ifc)
   begin
      if (load_main_skid)
         main_beat <= skid_beat;
      else if (load_main_rx)
         main_beat <= rx_beat;

      if (load_skid)
         skid_beat <= rx_beat;
   end

   // Main entry drives the internal stream
   assign out_s.valid = main_valid;
   assign {out_s.dm_mode, out_s.last, out_s.keep, out_s.data} = main_beat;

endmodule

//--- lb_fifo.sv
// Loopback buffer, a circular FIFO of beats with a registered head and back-pressure
`include "lb_cfg.svh"

module lb_fifo (
   input  logic     plat_ifc,
   input  logic     arst_n,
   lb_stream_if.snk in_s,
   lb_stream_if.src out_s
);

   import lb_pkg::*;

   localparam int DEPTH  = `LB_FIFO_DEPTH;
   localparam int PTR_W  = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int BEAT_W = $bits(lb_data_t) + $bits(lb_keep_t) + 2;

   logic [BEAT_W-1:0] mem [DEPTH];
   logic [BEAT_W-1:0] wr_beat;
   logic [BEAT_W-1:0] head_q;
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W-1:0]  rd_ptr_nxt;
   logic [CNT_W-1:0]  count;
   logic              full;
   logic              wr_fire;
   logic              rd_fire;
   logic              bypass;

   // --------------------------------------------------
   // Handshakes
   // --------------------------------------------------

   assign full    = (count == CNT_W'(DEPTH));
   assign wr_beat = {in_s.dm_mode, in_s.last, in_s.keep, in_s.data};

   // A full buffer still accepts when the head leaves in the same cycle
   assign in_s.ready  = ~full | out_s.ready;
   assign out_s.valid = (count != '0);

   assign wr_fire = in_s.valid & in_s.ready;
   assign rd_fire = out_s.valid & out_s.ready;

   // Slot that holds the head after this edge
   assign rd_ptr_nxt = rd_fire ? rd_ptr + PTR_W'(1) : rd_ptr;

   // Beat written into an empty slot goes straight to the head register
   assign bypass = wr_fire & (wr_ptr == rd_ptr_nxt);

   // --------------------------------------------------
   // Pointers and count
   // --------------------------------------------------

   always_ff @(posedge plat_ifc or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         rd_ptr <= rd_ptr_nxt;
         if (wr_fire)
            wr_ptr <= wr_ptr + PTR_W'(1);
         // Both at once leaves the count alone
         if (wr_fire && !rd_fire)
            count <= count + CNT_W'(1);
         else if (rd_fire && !wr_fire)
            count <= count - CNT_W'(1);
      end
   end

   // Storage and head register
   always_ff @(posedge plat_ifc)
   begin
      if (wr_fire)
         mem[wr_ptr] <= wr_beat;
      head_q <= bypass ? wr_beat : mem[rd_ptr_nxt];
   end

   assign {out_s.dm_mode, out_s.last, out_s.keep, out_s.data} = head_q;

endmodule

//--- host_tx_framer.sv
// Transmit framer that tracks start of packet and marks end of packet per segment
`include "lb_cfg.svh"

module host_tx_framer (
   input  logic              plat_ifc,
   input  logic              arst_n,
   input  logic              tx_tready,
   lb_stream_if.snk          in_s,
   output logic              tx_tvalid,
   output lb_pkg::lb_data_t  tx_tdata,
   output lb_pkg::lb_keep_t  tx_tkeep,
   output logic              tx_tlast,
   output logic              tx_dm_mode,
   output logic              tx_sop,
   output lb_pkg::lb_seg_t   tx_eop
);

   import lb_pkg::*;

   logic sop_q;
   logic tx_fire;
   logic seg_found;

   // --------------------------------------------------
   // Stream to host tx channel
   // --------------------------------------------------

   // Host back-pressure goes straight to the buffer
   assign in_s.ready = tx_tready;

   assign tx_tvalid  = in_s.valid;
   assign tx_tdata   = in_s.data;
   assign tx_tkeep   = in_s.keep;
   assign tx_tlast   = in_s.last;
   assign tx_dm_mode = in_s.dm_mode;

   assign tx_fire = in_s.valid & tx_tready;

   // --------------------------------------------------
   // Start of packet
   // --------------------------------------------------

   // First beat after reset opens a packet
   // After that a beat opens one only if the previous beat was last
   always_ff @(posedge plat_ifc or negedge arst_n)
   begin
      if (!arst_n)
         sop_q <= 1'b1;
      else if (tx_fire)
         sop_q <= in_s.last;
   end

   assign tx_sop = sop_q;

   // --------------------------------------------------
   // End of packet
   // --------------------------------------------------

   // At most one mark, on the highest segment with payload
   // The mark is simply last, so non-last beats stay all zero
   always_comb
   begin
      tx_eop    = '0;
      seg_found = 1'b0;
      for (int s = `LB_NUM_SEG - 1; s >= 0; s--)
      begin
         if (!seg_found && in_s.keep[s * lb_seg_bytes])
         begin
            tx_eop[s] = in_s.last;
            seg_found = 1'b1;
         end
      end
   end

endmodule

//--- afu_loopback_top.sv
// Host channel loopback exerciser top with receive mapper, loopback buffer and tx framer
module afu_loopback_top (
   input  logic              plat_ifc,
   input  logic              arst_n,

   // Host receive channel
   input  logic              rx_tvalid,
   input  lb_pkg::lb_data_t  rx_tdata,
   input  lb_pkg::lb_keep_t  rx_tkeep,
   input  logic              rx_tlast,
   input  logic              rx_dm_mode,
   output logic              rx_tready,

   // Host transmit channel with explicit framing
   output logic              tx_tvalid,
   output lb_pkg::lb_data_t  tx_tdata,
   output lb_pkg::lb_keep_t  tx_tkeep,
   output logic              tx_tlast,
   output logic              tx_dm_mode,
   output logic              tx_sop,
   output lb_pkg::lb_seg_t   tx_eop,
   input  logic              tx_tready
);

   // --------------------------------------------------
   // Internal streams
   // --------------------------------------------------

   // Mapper to buffer
   lb_stream_if rx_s ();
   // Buffer to framer
   lb_stream_if lb_s ();

   // Registered skid stage on the host receive side
   host_rx_map u_rx_map (
      .plat_ifc   (plat_ifc),
      .arst_n     (arst_n),
      .rx_tvalid  (rx_tvalid),
      .rx_tdata   (rx_tdata),
      .rx_tkeep   (rx_tkeep),
      .rx_tlast   (rx_tlast),
      .rx_dm_mode (rx_dm_mode),
      .rx_tready  (rx_tready),
      .out_s      (rx_s)
   );

   // Loopback storage, absorbs tx back-pressure
   lb_fifo u_fifo (
      .plat_ifc (plat_ifc),
      .arst_n   (arst_n),
      .in_s     (rx_s),
      .out_s    (lb_s)
   );

   // SOP and EOP framing on the way back to the host
   host_tx_framer u_tx_framer (
      .plat_ifc   (plat_ifc),
      .arst_n     (arst_n),
      .tx_tready  (tx_tready),
      .in_s       (lb_s),
      .tx_tvalid  (tx_tvalid),
      .tx_tdata   (tx_tdata),
      .tx_tkeep   (tx_tkeep),
      .tx_tlast   (tx_tlast),
      .tx_dm_mode (tx_dm_mode),
      .tx_sop     (tx_sop),
      .tx_eop     (tx_eop)
   );

endmodule

//--- tb_checker.sv
// Loopback checker that queues rx beats, checks tx beats and framing, and reports error counts
`include "lb_cfg.svh"

module tb_checker (
   input  logic             plat_ifc,
   input  logic             arst_n,
   input  logic             rx_tvalid,
   input  lb_pkg::lb_data_t rx_tdata,
   input  lb_pkg::lb_keep_t rx_tkeep,
   input  logic             rx_tlast,
   input  logic             rx_dm_mode,
   input  logic             rx_tready,
   input  logic             tx_tvalid,
   input  lb_pkg::lb_data_t tx_tdata,
   input  lb_pkg::lb_keep_t tx_tkeep,
   input  logic             tx_tlast,
   input  logic             tx_dm_mode,
   input  logic             tx_sop,
   input  lb_pkg::lb_seg_t  tx_eop,
   input  logic             tx_tready,
   input  logic             test_done,
   output int               pending,
   output int               err_total
);

   import lb_pkg::*;

   localparam int BEAT_W = $bits(lb_data_t) + $bits(lb_keep_t) + 2;

   typedef logic [BEAT_W-1:0] beat_t;

   // Beats accepted on rx and not yet seen on tx, oldest first
   beat_t beat_q [$];
   logic  prev_last   = 1'b1;
   logic  first_cycle = 1'b1;
   int    compared    = 0;
   int    value_errs  = 0;
   int    proto_errs  = 0;

   assign err_total = value_errs + proto_errs;

   // --------------------------------------------------
   // Reference framing
   // --------------------------------------------------

   // Returns {sop, eop}
   // SOP after reset or after a last beat, EOP on the highest segment with payload
   function automatic logic [`LB_NUM_SEG:0] ref_framing(input lb_keep_t keep,
                                                         input logic     last,
                                                         input logic     after_last);
      lb_keep_t shifted;
      lb_seg_t  eop;
      int       top_seg;
      top_seg = -1;
      for (int s = 0; s < `LB_NUM_SEG; s++)
      begin
         shifted = keep >> (s * lb_seg_bytes);
         if (shifted[0])
            top_seg = s;
      end
      eop = '0;
      if (last && top_seg >= 0)
         eop = lb_seg_t'(1) << top_seg;
      return {after_last, eop};
   endfunction

   task automatic compare_field(input string name, input logic [63:0] expv,
                                input logic [63:0] got);
      if (expv !== got)
      begin
         $display("FAIL %s: expected 0x%h, got 0x%h at time %0t", name, expv, got, $time);
         value_errs++;
      end
   endtask

   task automatic check_tx_beat();
      lb_data_t             exp_data;
      lb_keep_t             exp_keep;
      logic                 exp_last;
      logic                 exp_mode;
      logic [`LB_NUM_SEG:0] framing;
      if (beat_q.size() == 0)
      begin
         $display("Unexpected tx beat with no rx beat waiting at time %0t", $time);
         proto_errs++;
      end
      else
      begin
         {exp_mode, exp_last, exp_keep, exp_data} = beat_q.pop_front();
         framing = ref_framing(exp_keep, exp_last, prev_last);
         compare_field("tx_tdata", 64'(exp_data), 64'(tx_tdata));
         compare_field("tx_tkeep", 64'(exp_keep), 64'(tx_tkeep));
         compare_field("tx_tlast", 64'(exp_last), 64'(tx_tlast));
         compare_field("tx_dm_mode", 64'(exp_mode), 64'(tx_dm_mode));
         compare_field("tx_sop", 64'(framing[`LB_NUM_SEG]), 64'(tx_sop));
         compare_field("tx_eop", 64'(framing[`LB_NUM_SEG-1:0]), 64'(tx_eop));
         prev_last = exp_last;
         compared++;
      end
   endtask

   // --------------------------------------------------
   // Monitor
   // --------------------------------------------------

   // Sampled mid-cycle, so the values are the ones seen at the next rising edge
   always @(negedge plat_ifc)
   begin
      if (!arst_n)
      begin
         compare_field("tx_tvalid", 64'(1'b0), 64'(tx_tvalid));
         prev_last   = 1'b1;
         first_cycle = 1'b1;
      end
      else
      begin
         // Idle state right after reset
         if (first_cycle)
         begin
            compare_field("rx_tready", 64'(1'b1), 64'(rx_tready));
            compare_field("tx_tvalid", 64'(1'b0), 64'(tx_tvalid));
            first_cycle = 1'b0;
         end
         // Pop before push, an empty queue must flag a stray tx beat
         if (tx_tvalid && tx_tready)
            check_tx_beat();
         if (rx_tvalid && rx_tready)
            beat_q.push_back({rx_dm_mode, rx_tlast, rx_tkeep, rx_tdata});
      end
      pending = beat_q.size();
   end

   // Closing report
   always @(posedge test_done)
   begin
      if (beat_q.size() != 0)
      begin
         $display("%0d rx beats were never returned on tx", beat_q.size());
         proto_errs++;
      end
      $display("Checker: %0d beats compared, %0d value errors, %0d protocol errors",
               compared, value_errs, proto_errs);
   end

endmodule

//--- tb_top.sv
// Testbench top for the loopback exerciser with clock, reset, random packets and back-pressure
`include "lb_cfg.svh"

module tb_top;

   import lb_pkg::*;

   localparam int NUM_PKTS     = 200;
   localparam int MAX_BEATS    = 6;
   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DLY    = 2;
   localparam int WATCHDOG_T   = NUM_PKTS * MAX_BEATS * 8 * CLK_PERIOD;
   // Enough to empty the buffer and both skid entries with tx always ready
   localparam int DRAIN_CYCLES = 8 * (`LB_FIFO_DEPTH + 2);

   logic     plat_ifc;
   logic     arst_n;
   logic     rx_tvalid;
   lb_data_t rx_tdata;
   lb_keep_t rx_tkeep;
   logic     rx_tlast;
   logic     rx_dm_mode;
   logic     rx_tready;
   logic     tx_tvalid;
   lb_data_t tx_tdata;
   lb_keep_t tx_tkeep;
   logic     tx_tlast;
   logic     tx_dm_mode;
   logic     tx_sop;
   lb_seg_t  tx_eop;
   logic     tx_tready;
   logic     test_done;
   logic     drain;
   int       pending;
   int       err_total;
   integer   seed    = 32'hdbcc;
   // Back-pressure draws from its own stream
   integer   bp_seed = 32'hdbcc + 1;

   afu_loopback_top u_dut (.*);

   tb_checker u_chk (.*);

   initial
   begin
      plat_ifc = 1'b0;
      forever #(CLK_PERIOD / 2) plat_ifc = ~plat_ifc;
   end

   // --------------------------------------------------
   // Stimulus helpers
   // --------------------------------------------------

   // Base keep bit of every segment
   function automatic lb_keep_t seg_base_bits();
      lb_keep_t m;
      m = '0;
      for (int s = 0; s < `LB_NUM_SEG; s++)
         m = m | (lb_keep_t'(1) << (s * lb_seg_bytes));
      return m;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge plat_ifc);
         #DRIVE_DLY;
      end
   endtask

   // Holds the beat until the host channel accepts it
   task automatic send_beat(input lb_data_t data, input lb_keep_t keep,
                            input logic last, input logic mode);
      logic accepted;
      rx_tvalid  = 1'b1;
      rx_tdata   = data;
      rx_tkeep   = keep;
      rx_tlast   = last;
      rx_dm_mode = mode;
      accepted   = 1'b0;
      while (!accepted)
      begin
         // rx_tready comes from a flop and holds for the rest of the cycle
         accepted = rx_tready;
         @(posedge plat_ifc);
         #DRIVE_DLY;
      end
      rx_tvalid = 1'b0;
   endtask

   // --------------------------------------------------
   // Packet stimulus and end of run
   // --------------------------------------------------

   initial
   begin : stimulus
      logic [31:0] r;
      int          len;
      int          waited;
      lb_keep_t    keep;
      lb_data_t    data;
      arst_n     = 1'b0;
      rx_tvalid  = 1'b0;
      rx_tdata   = '0;
      rx_tkeep   = '0;
      rx_tlast   = 1'b0;
      rx_dm_mode = 1'b0;
      test_done  = 1'b0;
      drain      = 1'b0;
      repeat (5) @(posedge plat_ifc);
      #DRIVE_DLY;
      arst_n = 1'b1;
      idle_cycles(2);

      for (int p = 0; p < NUM_PKTS; p++)
      begin
         r   = $random(seed);
         len = int'(r[15:0] % 16'(MAX_BEATS)) + 1;
         for (int b = 0; b < len; b++)
         begin
            r    = $random(seed);
            data = {$random(seed), $random(seed)};
            case (r[1:0])
               // Lower segment only
               2'b00: keep = lb_keep_t'({lb_seg_bytes{1'b1}});
               // Partial bytes in both segments
               2'b01: keep = lb_keep_t'(r[31:8]) | seg_base_bits();
               default: keep = '1;
            endcase
            send_beat(data, keep, b == len - 1, r[2]);
            if (r[6:5] == 2'b00)
               idle_cycles(int'(r[8:7]) + 1);
         end
      end

      // Let the buffer empty with tx always ready
      drain  = 1'b1;
      waited = 0;
      while (pending != 0 && waited < DRAIN_CYCLES)
      begin
         @(posedge plat_ifc);
         waited++;
      end
      idle_cycles(10);
      test_done = 1'b1;
      #1;
      if (err_total == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // Random tx back-pressure with occasional long stalls that fill the buffer
   initial
   begin : back_pressure
      logic [31:0] r;
      int          stall;
      tx_tready = 1'b0;
      stall     = 0;
      @(posedge arst_n);
      forever
      begin
         @(posedge plat_ifc);
         #DRIVE_DLY;
         r = $random(bp_seed);
         if (drain)
            tx_tready = 1'b1;
         else if (stall > 0)
         begin
            tx_tready = 1'b0;
            stall--;
         end
         else if (r[4:2] == 3'b000)
         begin
            tx_tready = 1'b0;
            stall     = int'(r[9:7]) + 4;
         end
         else
            tx_tready = r[0] | r[1];
      end
   end

   initial
   begin : watchdog
      #(WATCHDOG_T);
      $display("Watchdog expired after %0d time units with %0d beats pending",
               WATCHDOG_T, pending);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
lb_pkg.sv
lb_stream_if.sv
host_rx_map.sv
lb_fifo.sv
host_tx_framer.sv
afu_loopback_top.sv
tb_checker.sv
tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the loopback testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_top --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
